//--- design/ddr_ctrl_pkg.sv
`default_nettype none

package ddr_ctrl_pkg;

    // Geometry
    localparam int BANK_BITS = 3;
    localparam int ROW_BITS = 14;
    localparam int COL_BITS = 10;
    localparam int DATA_BITS = 16;
    localparam int BURST_LENGTH = 8;
    localparam int HALF_BURST_LENGTH = BURST_LENGTH / 2;  // Two beats per clock
    localparam int BYTE_SEL_BITS = 1;
    localparam int ADDRESS_BITS = BANK_BITS + ROW_BITS + COL_BITS + BYTE_SEL_BITS;
    localparam int BURST_BITS = BURST_LENGTH * DATA_BITS;
    localparam int DDR_ADDR_BITS = 15;

    // Timing in clocks
    localparam int T_RCD = 4;
    localparam int T_RP = 4;
    localparam int T_RFC = 20;
    localparam int T_REFI = 200;  // Scaled down for simulation
    localparam int CAS_READ_LATENCY = 5;
    localparam int CAS_WRITE_LATENCY = 5;
    localparam int WRITE_RECOVERY = 5;
    localparam int COUNTER_BITS = 8;
    localparam int REFRESH_COUNTER_BITS = $clog2(T_REFI);

    // Bits are CS, RAS, CAS, WE
    typedef enum logic [3:0] {
        CMD_NOP      = 4'b0111,
        CMD_ACTIVATE = 4'b0011,
        CMD_READ     = 4'b0101,
        CMD_WRITE    = 4'b0100,
        CMD_REFRESH  = 4'b0001
    } ddr_cmd_e;

    typedef enum logic [2:0] {
        BS_PRECHARGED,
        BS_ACTIVATE_ROW,
        BS_OP,
        BS_READ,
        BS_READ_END,
        BS_WRITE,
        BS_WRITE_END
    } bank_state_e;

endpackage

`default_nettype wire

//--- design/refresh_timer.sv
`timescale 1ns/1ns
`default_nettype none

module refresh_timer
    import ddr_ctrl_pkg::*;
(
    input  logic ddr_clock_i,
    input  logic reset_i,
    input  logic refresh_taken_i,
    output logic refresh_pending_o
);

    logic [REFRESH_COUNTER_BITS-1:0] refresh_counter;

    // Period is exactly T_REFI clocks
    always_ff @(posedge ddr_clock_i) begin
        if (reset_i) begin
            refresh_counter <= REFRESH_COUNTER_BITS'(T_REFI - 1);
            refresh_pending_o <= 1'b0;
        end else if (refresh_counter == '0) begin
            refresh_counter <= REFRESH_COUNTER_BITS'(T_REFI - 1);
            refresh_pending_o <= 1'b1;  // New request wins over a late take
        end else begin
            refresh_counter <= refresh_counter - 1'b1;
            if (refresh_taken_i)
                refresh_pending_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- design/bank_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module bank_sequencer
    import ddr_ctrl_pkg::*;
(
    input  logic                     ddr_clock_i,
    input  logic                     reset_i,
    input  logic                     cmd_valid_i,
    input  logic                     cmd_write_i,
    input  logic [ADDRESS_BITS-1:0]  cmd_addr_i,
    input  logic                     refresh_pending_i,
    output logic                     cmd_ack_o,
    output logic                     refresh_taken_o,
    output logic                     load_write_o,
    output logic                     capture_read_o,
    output logic                     rsp_valid_o,
    output logic                     data_write_o,
    output logic                     data_transfer_o,
    output logic                     ddr3_ras_n_o,
    output logic                     ddr3_cas_n_o,
    output logic                     ddr3_we_n_o,
    output logic                     ddr3_cs_n_o,
    output logic [BANK_BITS-1:0]     ddr3_ba_o,
    output logic [DDR_ADDR_BITS-1:0] ddr3_addr_o
);

    bank_state_e bank_state;
    ddr_cmd_e ddr_cmd;
    logic [COUNTER_BITS-1:0] phase_counter;
    logic counter_zero;
    logic accept;
    logic [ADDRESS_BITS-1:0] op_addr;
    logic op_write;
    logic [BANK_BITS-1:0] op_bank;
    logic [ROW_BITS-1:0] op_row;
    logic [COL_BITS-1:0] op_col;

    assign op_bank = op_addr[ADDRESS_BITS-1 -: BANK_BITS];
    assign op_row = op_addr[BYTE_SEL_BITS+COL_BITS +: ROW_BITS];
    assign op_col = op_addr[BYTE_SEL_BITS +: COL_BITS];

    assign {ddr3_cs_n_o, ddr3_ras_n_o, ddr3_cas_n_o, ddr3_we_n_o} = ddr_cmd;

    assign accept = bank_state == BS_PRECHARGED && counter_zero && !refresh_pending_i
                    && cmd_valid_i;

    // One cycle ahead of the first data beat / after the last read beat
    assign load_write_o = bank_state == BS_WRITE && counter_zero;
    assign capture_read_o = bank_state == BS_READ_END && counter_zero;

    always_ff @(posedge ddr_clock_i) begin
        if (accept) begin
            op_addr <= cmd_addr_i;
            op_write <= cmd_write_i;
        end
    end

    always_ff @(posedge ddr_clock_i) begin
        if (reset_i) begin
            bank_state <= BS_PRECHARGED;
            phase_counter <= '0;
            counter_zero <= 1'b1;
            ddr_cmd <= CMD_NOP;
            ddr3_ba_o <= '0;
            ddr3_addr_o <= '0;
            cmd_ack_o <= 1'b0;
            refresh_taken_o <= 1'b0;
            rsp_valid_o <= 1'b0;
            data_write_o <= 1'b0;
            data_transfer_o <= 1'b0;
        end else begin
            ddr_cmd <= CMD_NOP;
            ddr3_ba_o <= '0;
            ddr3_addr_o <= '0;
            cmd_ack_o <= 1'b0;
            refresh_taken_o <= 1'b0;
            rsp_valid_o <= 1'b0;

            if (!counter_zero) begin
                phase_counter <= phase_counter - 1'b1;
                counter_zero <= phase_counter == COUNTER_BITS'(1);
            end else begin
                case (bank_state)
                    BS_PRECHARGED: begin
                        if (refresh_pending_i) begin  // Refresh beats user commands
                            ddr_cmd <= CMD_REFRESH;
                            refresh_taken_o <= 1'b1;
                            phase_counter <= COUNTER_BITS'(T_RFC);
                            counter_zero <= 1'b0;
                        end else if (accept) begin
                            cmd_ack_o <= 1'b1;
                            bank_state <= BS_ACTIVATE_ROW;
                        end
                    end
                    BS_ACTIVATE_ROW: begin
                        ddr_cmd <= CMD_ACTIVATE;
                        ddr3_ba_o <= op_bank;
                        ddr3_addr_o <= DDR_ADDR_BITS'(op_row);
                        bank_state <= BS_OP;
                        phase_counter <= COUNTER_BITS'(T_RCD);
                        counter_zero <= 1'b0;
                    end
                    BS_OP: begin
                        data_transfer_o <= 1'b1;
                        ddr3_ba_o <= op_bank;
                        ddr3_addr_o <= {{(DDR_ADDR_BITS-COL_BITS-1){1'b0}}, 1'b1, op_col};
                        counter_zero <= 1'b0;
                        if (op_write) begin
                            ddr_cmd <= CMD_WRITE;
                            bank_state <= BS_WRITE;
                            phase_counter <= COUNTER_BITS'(CAS_WRITE_LATENCY - 1);
                        end else begin
                            ddr_cmd <= CMD_READ;
                            bank_state <= BS_READ;
                            phase_counter <= COUNTER_BITS'(CAS_READ_LATENCY - 1);
                        end
                    end
                    BS_WRITE: begin
                        data_write_o <= 1'b1;
                        bank_state <= BS_WRITE_END;
                        phase_counter <= COUNTER_BITS'(HALF_BURST_LENGTH - 1);
                        counter_zero <= 1'b0;
                    end
                    BS_READ: begin
                        // Extra clock lets the last lane pair reach the shifter
                        bank_state <= BS_READ_END;
                        phase_counter <= COUNTER_BITS'(HALF_BURST_LENGTH);
                        counter_zero <= 1'b0;
                    end
                    BS_WRITE_END: begin
                        data_write_o <= 1'b0;
                        data_transfer_o <= 1'b0;
                        bank_state <= BS_PRECHARGED;
                        phase_counter <= COUNTER_BITS'(T_RP + WRITE_RECOVERY);
                        counter_zero <= 1'b0;
                    end
                    BS_READ_END: begin
                        data_transfer_o <= 1'b0;
                        rsp_valid_o <= 1'b1;
                        bank_state <= BS_PRECHARGED;
                        phase_counter <= COUNTER_BITS'(T_RP);
                        counter_zero <= 1'b0;
                    end
                    default: bank_state <= BS_PRECHARGED;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- design/burst_shifter.sv
`timescale 1ns/1ns
`default_nettype none

module burst_shifter
    import ddr_ctrl_pkg::*;
(
    input  logic                  ddr_clock_i,
    input  logic                  reset_i,
    input  logic                  load_write_i,
    input  logic                  capture_read_i,
    input  logic [BURST_BITS-1:0] cmd_data_i,
    input  logic [DATA_BITS-1:0]  ddr3_dq_rise_i,
    input  logic [DATA_BITS-1:0]  ddr3_dq_fall_i,
    output logic [DATA_BITS-1:0]  ddr3_dq_rise_o,
    output logic [DATA_BITS-1:0]  ddr3_dq_fall_o,
    output logic [BURST_BITS-1:0] rsp_data_o
);

    // Even beats ride the rising lane, odd beats the falling lane
    logic [HALF_BURST_LENGTH*DATA_BITS-1:0] even_q, odd_q;
    logic [HALF_BURST_LENGTH*DATA_BITS-1:0] even_load, odd_load;
    logic [BURST_BITS-1:0] read_word;

    always_comb begin
        for (int i = 0; i < HALF_BURST_LENGTH; i++) begin
            even_load[i*DATA_BITS +: DATA_BITS] = cmd_data_i[2*i*DATA_BITS +: DATA_BITS];
            odd_load[i*DATA_BITS +: DATA_BITS] = cmd_data_i[(2*i+1)*DATA_BITS +: DATA_BITS];
            read_word[2*i*DATA_BITS +: DATA_BITS] = even_q[i*DATA_BITS +: DATA_BITS];
            read_word[(2*i+1)*DATA_BITS +: DATA_BITS] = odd_q[i*DATA_BITS +: DATA_BITS];
        end
    end

    always_ff @(posedge ddr_clock_i) begin
        if (reset_i) begin
            even_q <= '0;
            odd_q <= '0;
        end else if (load_write_i) begin
            even_q <= even_load;
            odd_q <= odd_load;
        end else begin
            // Shift toward the outputs, read lanes enter at the top
            even_q <= {ddr3_dq_rise_i, even_q[HALF_BURST_LENGTH*DATA_BITS-1:DATA_BITS]};
            odd_q <= {ddr3_dq_fall_i, odd_q[HALF_BURST_LENGTH*DATA_BITS-1:DATA_BITS]};
        end
    end

    always_ff @(posedge ddr_clock_i) begin
        if (capture_read_i)
            rsp_data_o <= read_word;  // Held until the next read
    end

    assign ddr3_dq_rise_o = even_q[DATA_BITS-1:0];
    assign ddr3_dq_fall_o = odd_q[DATA_BITS-1:0];

endmodule

`default_nettype wire

//--- design/ddr_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module ddr_ctrl_top
    import ddr_ctrl_pkg::*;
(
    input  logic                     ddr_clock_i,
    input  logic                     reset_i,
    input  logic                     cmd_valid_i,
    input  logic [ADDRESS_BITS-1:0]  cmd_addr_i,
    input  logic                     cmd_write_i,
    input  logic [BURST_BITS-1:0]    cmd_data_i,
    output logic                     cmd_ack_o,
    output logic                     rsp_valid_o,
    output logic [BURST_BITS-1:0]    rsp_data_o,
    output logic                     ddr_reset_n_o,
    output logic                     ddr3_cke_o,
    output logic                     ddr3_odt_o,
    output logic                     ddr3_ras_n_o,
    output logic                     ddr3_cas_n_o,
    output logic                     ddr3_we_n_o,
    output logic                     ddr3_cs_n_o,
    output logic [BANK_BITS-1:0]     ddr3_ba_o,
    output logic [DDR_ADDR_BITS-1:0] ddr3_addr_o,
    output logic [DATA_BITS-1:0]     ddr3_dq_rise_o,
    output logic [DATA_BITS-1:0]     ddr3_dq_fall_o,
    input  logic [DATA_BITS-1:0]     ddr3_dq_rise_i,
    input  logic [DATA_BITS-1:0]     ddr3_dq_fall_i,
    output logic                     data_write_o,
    output logic                     data_transfer_o
);

    logic refresh_pending, refresh_taken;
    logic load_write, capture_read;

    assign ddr_reset_n_o = !reset_i;
    assign ddr3_cke_o = !reset_i;
    assign ddr3_odt_o = data_write_o;  // Termination on during write bursts

    refresh_timer i_refresh_timer (
        .ddr_clock_i       (ddr_clock_i),
        .reset_i           (reset_i),
        .refresh_taken_i   (refresh_taken),
        .refresh_pending_o (refresh_pending)
    );

    bank_sequencer i_bank_sequencer (
        .ddr_clock_i       (ddr_clock_i),
        .reset_i           (reset_i),
        .cmd_valid_i       (cmd_valid_i),
        .cmd_write_i       (cmd_write_i),
        .cmd_addr_i        (cmd_addr_i),
        .refresh_pending_i (refresh_pending),
        .cmd_ack_o         (cmd_ack_o),
        .refresh_taken_o   (refresh_taken),
        .load_write_o      (load_write),
        .capture_read_o    (capture_read),
        .rsp_valid_o       (rsp_valid_o),
        .data_write_o      (data_write_o),
        .data_transfer_o   (data_transfer_o),
        .ddr3_ras_n_o      (ddr3_ras_n_o),
        .ddr3_cas_n_o      (ddr3_cas_n_o),
        .ddr3_we_n_o       (ddr3_we_n_o),
        .ddr3_cs_n_o       (ddr3_cs_n_o),
        .ddr3_ba_o         (ddr3_ba_o),
        .ddr3_addr_o       (ddr3_addr_o)
    );

    burst_shifter i_burst_shifter (
        .ddr_clock_i    (ddr_clock_i),
        .reset_i        (reset_i),
        .load_write_i   (load_write),
        .capture_read_i (capture_read),
        .cmd_data_i     (cmd_data_i),
        .ddr3_dq_rise_i (ddr3_dq_rise_i),
        .ddr3_dq_fall_i (ddr3_dq_fall_i),
        .ddr3_dq_rise_o (ddr3_dq_rise_o),
        .ddr3_dq_fall_o (ddr3_dq_fall_o),
        .rsp_data_o     (rsp_data_o)
    );

endmodule

`default_nettype wire

//--- tb/ddr_ctrl_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module ddr_ctrl_assertions
    import ddr_ctrl_pkg::*;
(
    input logic ddr_clock_i,
    input logic reset_i,
    input logic cmd_valid_i,
    input logic cmd_ack_o,
    input logic rsp_valid_o,
    input logic data_write_o,
    input logic ddr3_cs_n_o,
    input logic ddr3_ras_n_o,
    input logic ddr3_cas_n_o,
    input logic ddr3_we_n_o
);

    logic [3:0] cmd_bits;
    logic is_activate;

    assign cmd_bits = {ddr3_cs_n_o, ddr3_ras_n_o, ddr3_cas_n_o, ddr3_we_n_o};
    assign is_activate = cmd_bits == CMD_ACTIVATE;

    ack_needs_valid: assert property (@(posedge ddr_clock_i) disable iff (reset_i)
        cmd_ack_o |-> cmd_valid_i) else $error("ack without valid");

    ack_one_cycle: assert property (@(posedge ddr_clock_i) disable iff (reset_i)
        cmd_ack_o |=> !cmd_ack_o) else $error("ack longer than one cycle");

    rsp_one_cycle: assert property (@(posedge ddr_clock_i) disable iff (reset_i)
        rsp_valid_o |=> !rsp_valid_o) else $error("response valid longer than one cycle");

    no_refresh_in_write: assert property (@(posedge ddr_clock_i) disable iff (reset_i)
        data_write_o |-> cmd_bits != CMD_REFRESH) else $error("refresh during write burst");

    // T_RCD window of four clocks
    quiet_after_activate: assert property (@(posedge ddr_clock_i) disable iff (reset_i)
        cmd_bits != CMD_NOP |-> !($past(is_activate, 1) || $past(is_activate, 2)
            || $past(is_activate, 3) || $past(is_activate, 4)))
        else $error("command too soon after activate");

endmodule

bind bank_sequencer ddr_ctrl_assertions i_ddr_ctrl_assertions (.*);

`default_nettype wire

//--- tb/tb_ddr_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ddr_ctrl
    import ddr_ctrl_pkg::*;
();

    localparam int MAX_CASES = 64;
    localparam int CASE_WORDS = 10;  // op, address, eight beats
    localparam int ACK_TIMEOUT = T_REFI + 100;
    localparam int DONE_TIMEOUT = 100;
    localparam int MAX_TRANSACTION = 40;
    localparam int KEY_BITS = BANK_BITS + ROW_BITS + COL_BITS;

    logic ddr_clock = 1'b0;
    logic reset;
    logic cmd_valid, cmd_write;
    logic [ADDRESS_BITS-1:0] cmd_addr;
    logic [BURST_BITS-1:0] cmd_data;
    logic [DATA_BITS-1:0] dq_rise_in = '0;
    logic [DATA_BITS-1:0] dq_fall_in = '0;
    logic cmd_ack_o, rsp_valid_o, ddr_reset_n_o, ddr3_cke_o, ddr3_odt_o;
    logic ddr3_ras_n_o, ddr3_cas_n_o, ddr3_we_n_o, ddr3_cs_n_o;
    logic [BANK_BITS-1:0] ddr3_ba_o;
    logic [DDR_ADDR_BITS-1:0] ddr3_addr_o;
    logic [DATA_BITS-1:0] ddr3_dq_rise_o, ddr3_dq_fall_o;
    logic [BURST_BITS-1:0] rsp_data_o;
    logic data_write_o, data_transfer_o;

    logic [31:0] case_mem [0:MAX_CASES*CASE_WORDS-1];
    logic [BURST_BITS-1:0] ref_mem [logic [ADDRESS_BITS-2:0]];  // Testbench copy
    logic [BURST_BITS-1:0] ddr_mem [logic [KEY_BITS-1:0]];      // DDR model storage
    logic [BURST_BITS-1:0] exp_rsp [$];
    int rsp_case [$];

    // Current case as seen by the bus monitor
    logic [ADDRESS_BITS-1:0] cur_addr;
    logic cur_write;
    logic [BURST_BITS-1:0] cur_data;
    int cur_case;

    int error_count = 0;
    int check_count = 0;
    int ack_count = 0;
    int rsp_count = 0;
    int refresh_count = 0;
    int last_refresh = 0;
    int cycle = 0;

    // DDR model state
    logic [3:0] cmd_bits;
    logic [BANK_BITS-1:0] act_bank;
    logic [ROW_BITS-1:0] act_row;
    logic [KEY_BITS-1:0] wr_key;
    logic [BURST_BITS-1:0] write_word;
    logic [BURST_BITS-1:0] rd_word;
    int write_beat = 0;
    int rd_start = -100;
    int wr_start = -100;
    logic in_window;
    int beat;

    always #20 ddr_clock = ~ddr_clock;

    ddr_ctrl_top i_ddr_ctrl_top (
        .ddr_clock_i     (ddr_clock),
        .reset_i         (reset),
        .cmd_valid_i     (cmd_valid),
        .cmd_addr_i      (cmd_addr),
        .cmd_write_i     (cmd_write),
        .cmd_data_i      (cmd_data),
        .cmd_ack_o       (cmd_ack_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_data_o      (rsp_data_o),
        .ddr_reset_n_o   (ddr_reset_n_o),
        .ddr3_cke_o      (ddr3_cke_o),
        .ddr3_odt_o      (ddr3_odt_o),
        .ddr3_ras_n_o    (ddr3_ras_n_o),
        .ddr3_cas_n_o    (ddr3_cas_n_o),
        .ddr3_we_n_o     (ddr3_we_n_o),
        .ddr3_cs_n_o     (ddr3_cs_n_o),
        .ddr3_ba_o       (ddr3_ba_o),
        .ddr3_addr_o     (ddr3_addr_o),
        .ddr3_dq_rise_o  (ddr3_dq_rise_o),
        .ddr3_dq_fall_o  (ddr3_dq_fall_o),
        .ddr3_dq_rise_i  (dq_rise_in),
        .ddr3_dq_fall_i  (dq_fall_in),
        .data_write_o    (data_write_o),
        .data_transfer_o (data_transfer_o)
    );

    task automatic check_value(input string name, input logic [BURST_BITS-1:0] expected,
                               input logic [BURST_BITS-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic wait_for_ack(input int idx);
        int waited;
        for (waited = 0; waited < ACK_TIMEOUT; waited++) begin
            @(posedge ddr_clock);
            if (cmd_ack_o)
                break;
        end
        cmd_valid <= 1'b0;
        if (waited == ACK_TIMEOUT) begin
            $display("case %0d got no ack within %0d cycles", idx, ACK_TIMEOUT);
            error_count++;
        end
    endtask

    task automatic wait_for_write_end(input int idx);
        int waited;
        bit seen;
        seen = 0;
        for (waited = 0; waited < DONE_TIMEOUT; waited++) begin
            @(posedge ddr_clock);
            if (data_write_o)
                seen = 1;
            else if (seen)
                break;
        end
        if (waited == DONE_TIMEOUT) begin
            $display("case %0d write burst did not finish in time", idx);
            error_count++;
        end
    endtask

    task automatic wait_for_response(input int idx);
        int waited;
        for (waited = 0; waited < DONE_TIMEOUT; waited++) begin
            @(posedge ddr_clock);
            if (rsp_valid_o)
                break;
        end
        if (waited == DONE_TIMEOUT) begin
            $display("case %0d read returned no response in time", idx);
            error_count++;
        end
    endtask

    task automatic wait_for_refreshes(input int count);
        int waited;
        for (waited = 0; waited < 4 * T_REFI; waited++) begin
            @(posedge ddr_clock);
            if (refresh_count >= count)
                break;
        end
        if (waited == 4 * T_REFI) begin
            $display("only %0d refresh commands seen, wanted %0d", refresh_count, count);
            error_count++;
        end
    endtask

    // Bus monitor and DDR memory model sampling the cycle just ended
    always @(posedge ddr_clock) begin
        cycle = cycle + 1;
        cmd_bits = {ddr3_cs_n_o, ddr3_ras_n_o, ddr3_cas_n_o, ddr3_we_n_o};
        if (!reset) begin
            check_value("phy enables", BURST_BITS'(2'b11),
                        BURST_BITS'({ddr_reset_n_o, ddr3_cke_o}));
            if (cmd_ack_o) begin
                ack_count++;
                if (refresh_count > 0 && cycle - last_refresh <= T_RFC) begin
                    $display("ack came %0d cycles after REFRESH", cycle - last_refresh);
                    error_count++;
                end
            end
            if (rsp_valid_o) begin
                rsp_count++;
                if (exp_rsp.size() == 0) begin
                    $display("response without a pending read");
                    error_count++;
                end else
                    check_value($sformatf("case %0d read data", rsp_case.pop_front()),
                                exp_rsp.pop_front(), rsp_data_o);
            end
            case (cmd_bits)
                CMD_ACTIVATE: begin
                    check_value($sformatf("case %0d activate bank", cur_case),
                                BURST_BITS'(cur_addr[ADDRESS_BITS-1 -: BANK_BITS]),
                                BURST_BITS'(ddr3_ba_o));
                    check_value($sformatf("case %0d activate row", cur_case),
                                BURST_BITS'(cur_addr[BYTE_SEL_BITS+COL_BITS +: ROW_BITS]),
                                BURST_BITS'(ddr3_addr_o));
                    act_bank = ddr3_ba_o;
                    act_row = ddr3_addr_o[ROW_BITS-1:0];
                end
                CMD_READ, CMD_WRITE: begin
                    check_value($sformatf("case %0d command", cur_case),
                                BURST_BITS'(cur_write ? CMD_WRITE : CMD_READ),
                                BURST_BITS'(cmd_bits));
                    check_value($sformatf("case %0d bank", cur_case),
                                BURST_BITS'(cur_addr[ADDRESS_BITS-1 -: BANK_BITS]),
                                BURST_BITS'(ddr3_ba_o));
                    check_value($sformatf("case %0d column", cur_case),
                                BURST_BITS'(cur_addr[BYTE_SEL_BITS +: COL_BITS]),
                                BURST_BITS'(ddr3_addr_o[COL_BITS-1:0]));
                    check_value($sformatf("case %0d auto precharge", cur_case),
                                BURST_BITS'(1), BURST_BITS'(ddr3_addr_o[10]));
                    wr_key = {act_bank, act_row, ddr3_addr_o[COL_BITS-1:0]};
                    if (cmd_bits == CMD_WRITE) begin
                        write_beat = 0;
                        wr_start = cycle + CAS_WRITE_LATENCY;
                    end else begin
                        rd_word = ddr_mem.exists(wr_key) ? ddr_mem[wr_key] : '0;
                        rd_start = cycle + CAS_READ_LATENCY - 1;
                    end
                end
                CMD_REFRESH: begin
                    if (refresh_count > 0
                        && cycle - last_refresh > T_REFI + MAX_TRANSACTION) begin
                        $display("refresh gap of %0d cycles is too long", cycle - last_refresh);
                        error_count++;
                    end
                    refresh_count++;
                    last_refresh = cycle;
                end
                CMD_NOP: ;
                default: begin
                    $display("unknown DDR command %b", cmd_bits);
                    error_count++;
                end
            endcase
            // Write window and ODT from the WRITE command cycle
            in_window = cycle >= wr_start && cycle < wr_start + HALF_BURST_LENGTH;
            check_value($sformatf("case %0d write window", cur_case),
                        BURST_BITS'({in_window, in_window}),
                        BURST_BITS'({data_write_o, ddr3_odt_o}));
            if (data_write_o) begin
                check_value($sformatf("case %0d rise lane beat %0d", cur_case, 2 * write_beat),
                            BURST_BITS'(cur_data[2*write_beat*DATA_BITS +: DATA_BITS]),
                            BURST_BITS'(ddr3_dq_rise_o));
                check_value($sformatf("case %0d fall lane beat %0d", cur_case, 2 * write_beat + 1),
                            BURST_BITS'(cur_data[(2*write_beat+1)*DATA_BITS +: DATA_BITS]),
                            BURST_BITS'(ddr3_dq_fall_o));
                write_word[2*write_beat*DATA_BITS +: DATA_BITS] = ddr3_dq_rise_o;
                write_word[(2*write_beat+1)*DATA_BITS +: DATA_BITS] = ddr3_dq_fall_o;
                write_beat++;
                if (write_beat == HALF_BURST_LENGTH)
                    ddr_mem[wr_key] = write_word;
            end
        end
        // One read beat pair per clock
        if (cycle >= rd_start && cycle < rd_start + HALF_BURST_LENGTH) begin
            beat = cycle - rd_start;
            dq_rise_in <= rd_word[2*beat*DATA_BITS +: DATA_BITS];
            dq_fall_in <= rd_word[(2*beat+1)*DATA_BITS +: DATA_BITS];
        end else begin
            dq_rise_in <= '0;
            dq_fall_in <= '0;
        end
    end

    initial begin
        int idx;
        int gap;
        int case_count;
        int read_cases;
        logic [ADDRESS_BITS-2:0] key;
        void'($urandom(32'hf0d7_6199));
        reset = 1'b1;
        cmd_valid = 1'b0;
        cmd_write = 1'b0;
        cmd_addr = '0;
        cmd_data = '0;
        cur_addr = '0;
        cur_write = 1'b0;
        cur_data = '0;
        cur_case = 0;
        case_count = 0;
        read_cases = 0;
        for (idx = 0; idx < MAX_CASES * CASE_WORDS; idx++)
            case_mem[idx] = 32'hffff_ffff;  // End marker
        $readmemh("tb/ddr_cases.txt", case_mem);

        for (idx = 0; idx < 10; idx++) begin
            @(posedge ddr_clock);
            if (idx >= 2) begin
                check_value("reset command", BURST_BITS'(CMD_NOP), BURST_BITS'(
                    {ddr3_cs_n_o, ddr3_ras_n_o, ddr3_cas_n_o, ddr3_we_n_o}));
                check_value("reset controls", '0, BURST_BITS'({cmd_ack_o, rsp_valid_o,
                    data_write_o, data_transfer_o, ddr_reset_n_o, ddr3_cke_o, ddr3_odt_o}));
            end
        end
        reset <= 1'b0;

        for (idx = 0; idx < MAX_CASES; idx++) begin
            if (case_mem[idx*CASE_WORDS] == 32'hffff_ffff)
                break;
            gap = int'($urandom % 5);
            repeat (gap) @(posedge ddr_clock);
            cur_case = idx;
            cur_write = case_mem[idx*CASE_WORDS][0];
            cur_addr = case_mem[idx*CASE_WORDS+1][ADDRESS_BITS-1:0];
            for (int k = 0; k < BURST_LENGTH; k++)
                cur_data[k*DATA_BITS +: DATA_BITS] = case_mem[idx*CASE_WORDS+2+k][DATA_BITS-1:0];
            key = cur_addr[ADDRESS_BITS-1:BYTE_SEL_BITS];
            if (cur_write)
                ref_mem[key] = cur_data;
            else begin
                exp_rsp.push_back(ref_mem.exists(key) ? ref_mem[key] : '0);
                rsp_case.push_back(idx);
                read_cases++;
            end
            case_count++;
            cmd_valid <= 1'b1;
            cmd_write <= cur_write;
            cmd_addr <= cur_addr;
            cmd_data <= cur_data;
            wait_for_ack(idx);
            if (cur_write)
                wait_for_write_end(idx);
            else
                wait_for_response(idx);
        end

        wait_for_refreshes(3);
        repeat (5) @(posedge ddr_clock);
        check_value("ack count", BURST_BITS'(case_count), BURST_BITS'(ack_count));
        check_value("response count", BURST_BITS'(read_cases), BURST_BITS'(rsp_count));
        $display("checks %0d, errors %0d, refreshes %0d", check_count, error_count,
                 refresh_count);
        if (error_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/ddr_cases.txt
// op (1 write, 0 read), byte address, beats 0 to 7
1 A2468AC 0101 0202 0303 0404 0505 0606 0707 0808
0 A2468AC 0000 0000 0000 0000 0000 0000 0000 0000
1 1357A02 dead beef cafe f00d 1234 5678 9abc def0
0 0000010 0000 0000 0000 0000 0000 0000 0000 0000
1 FFFFFFE aaaa 5555 ffff 0000 a5a5 5a5a 0f0f f0f0
0 1357A02 0000 0000 0000 0000 0000 0000 0000 0000
1 A2468AC 1111 2222 3333 4444 5555 6666 7777 8888
0 A2468AC 0000 0000 0000 0000 0000 0000 0000 0000
0 FFFFFFE 0000 0000 0000 0000 0000 0000 0000 0000
1 4000400 8001 4002 2004 1008 0810 0420 0240 0180
0 4000401 0000 0000 0000 0000 0000 0000 0000 0000
1 6C00002 0001 0002 0004 0008 0010 0020 0040 0080
1 2000002 fedc ba98 7654 3210 0123 4567 89ab cdef
0 6C00002 0000 0000 0000 0000 0000 0000 0000 0000
0 2000002 0000 0000 0000 0000 0000 0000 0000 0000
0 A2468AC 0000 0000 0000 0000 0000 0000 0000 0000
1 1357A02 0f00 00f0 000f f000 0ff0 f00f 0aa0 a00a
0 1357A02 0000 0000 0000 0000 0000 0000 0000 0000

//--- compile.f
design/ddr_ctrl_pkg.sv
design/refresh_timer.sv
design/bank_sequencer.sv
design/burst_shifter.sv
design/ddr_ctrl_top.sv
tb/ddr_ctrl_assertions.sv
tb/tb_ddr_ctrl.sv

//--- Makefile
TOP = tb_ddr_ctrl

.PHONY: all run lint clean

all: run

obj_dir/$(TOP): compile.f design/*.sv tb/*.sv
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: obj_dir/$(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Everything OK" sim.log

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
